// File: src/fetch_pkg.sv
package fetch_pkg;

	// instruction and pc width
	parameter int XLEN = 32;

	// width of the response error code
	parameter int ERR_W = 2;

	// error code carried with every fetch response
	typedef enum logic [ERR_W-1:0]
	{
		IMEM_OK        = 2'b00,	// normal completion
		IMEM_UNALIGNED = 2'b01,	// pc not word aligned
		IMEM_BUS_ERR   = 2'b10,	// slave answered with err
		IMEM_TIMEOUT   = 2'b11	// no ack within the wait limit
	} imem_err_e;

	// coarse class of a fetched word, drives the static predictor
	typedef enum logic [1:0]
	{
		CLS_SEQ    = 2'b00,	// falls through to pc + 4
		CLS_JAL    = 2'b01,	// direct jump, always taken
		CLS_BRANCH = 2'b10,	// conditional, taken if backward
		CLS_JALR   = 2'b11	// indirect, left to the backend
	} inst_class_e;

endpackage

// File: src/wb_pkg.sv
package wb_pkg;

	// byte address width on the wishbone side
	parameter int ADDR_W = 32;

	// bus master FSM
	typedef enum logic [1:0]
	{
		WB_IDLE  = 2'b00,	// ready for a new request
		WB_CYCLE = 2'b01,	// cyc/stb held, waiting for ack/err
		WB_RESP  = 2'b10	// response pulse towards the controller
	} wb_state_e;

endpackage

// File: src/imem_req_if.sv
`timescale 1ns/1ps

interface imem_req_if;

	logic [fetch_pkg::XLEN-1:0] req_addr;	// fetch address
	logic req_valid;	// independent of req_ready
	logic req_ready;	// master can take a request
	logic rsp_valid;	// one-cycle pulse, never back-pressured
	logic [fetch_pkg::XLEN-1:0] rsp_rdata;	// fetched word
	fetch_pkg::imem_err_e rsp_err;	// completion status

	// controller side
	modport ctrl (output req_addr, req_valid,
		input req_ready, rsp_valid, rsp_rdata, rsp_err);

	// bus master side
	modport master (input req_addr, req_valid,
		output req_ready, rsp_valid, rsp_rdata, rsp_err);

endinterface

// File: src/pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
	parameter logic [31:0] RESET_PC = 32'h0000_0000
)(
	input logic first_fetch_i,
	input logic flushing_i,
	input logic [31:0] flush_addr_i,
	input logic [31:0] cur_pc_i,
	input logic pred_taken_i,
	input logic [31:0] pred_target_i,
	output logic [31:0] next_pc_o
);

	logic [31:0] seq_pc;	// fall-through address

	assign seq_pc = cur_pc_i + 32'd4;

	// flush wins over everything, then boot, then prediction
	always_comb
	begin
		if (flushing_i)
			next_pc_o = flush_addr_i;
		else if (first_fetch_i)
			next_pc_o = RESET_PC;
		else if (pred_taken_i)
			next_pc_o = pred_target_i;	// jal or backward branch
		else
			next_pc_o = seq_pc;
	end

endmodule

// File: src/pre_decoder.sv
`timescale 1ns/1ps

module pre_decoder (
	input logic [31:0] inst_i,
	input logic [31:0] pc_i,
	output logic pred_taken_o,
	output logic [31:0] pred_target_o,
	output logic illegal_o
);

	// rv32i major opcodes
	typedef enum logic [6:0]
	{
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_FENCE  = 7'b0001111,
		OPC_SYSTEM = 7'b1110011
	} opcode_e;

	opcode_e opc;
	fetch_pkg::inst_class_e cls;
	logic known;	// opcode in the rv32i set
	logic [31:0] imm_j, imm_b;

	assign opc = opcode_e'(inst_i[6:0]);
	assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
	assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

	always_comb
	begin
		cls = fetch_pkg::CLS_SEQ;
		known = 1'b1;
		case (opc)
			OPC_JAL: cls = fetch_pkg::CLS_JAL;
			OPC_JALR: cls = fetch_pkg::CLS_JALR;	// target unknown here
			OPC_BRANCH: cls = fetch_pkg::CLS_BRANCH;
			OPC_LUI, OPC_AUIPC, OPC_LOAD, OPC_STORE,
			OPC_OPIMM, OPC_OP, OPC_FENCE, OPC_SYSTEM: cls = fetch_pkg::CLS_SEQ;
			default: known = 1'b0;
		endcase
	end

	// backward branch = sign bit of the b-immediate
	assign pred_taken_o = (cls == fetch_pkg::CLS_JAL) | ((cls == fetch_pkg::CLS_BRANCH) & inst_i[31]);
	assign pred_target_o = pc_i + ((cls == fetch_pkg::CLS_JAL) ? imm_j : imm_b);
	assign illegal_o = (inst_i[1:0] != 2'b11) | ~known;	// compressed or unknown

endmodule

// File: src/fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl #(
	parameter int ID_W = 4
)(
	input logic clk,
	input logic resetn,
	input logic flush_i,
	input logic [31:0] flush_addr_i,
	imem_req_if.ctrl imem,
	output logic [31:0] cur_pc_o,	// pc of the word being pre-decoded
	output logic [31:0] cur_inst_o,	// word being pre-decoded
	output logic first_fetch_o,
	output logic flushing_o,
	output logic [31:0] flush_addr_hold_o,
	input logic [31:0] next_pc_i,
	input logic illegal_i,
	input logic pred_taken_i,
	output logic if_res_valid_o,
	input logic if_res_ready_i,
	output logic [31:0] if_res_pc_o,
	output logic [31:0] if_res_inst_o,
	output fetch_pkg::imem_err_e if_res_err_o,
	output logic if_res_pred_taken_o,
	output logic if_res_illegal_o,
	output logic [ID_W-1:0] if_res_id_o,
	output logic flush_ack_o
);

	logic req_fire, take, supp, vld_rsp, inst_vld;
	logic boot_q, first_q, flush_pend_q;
	logic [31:0] flush_addr_q;
	logic [2:0] out_cnt_q, out_cnt_base;	// issued but not handed off
	logic [1:0] iss_wptr_q, iss_rptr_q;	// per-request ring pointers
	logic [2:0] stale_q;	// request belongs to a pre-flush path
	logic [31:0] pc_buf [3];
	logic hold_vld_q;	// stall latch for the word waiting to issue
	logic [31:0] hold_inst_q, hold_pc_q;
	logic [1:0] buf_wptr_q, buf_rptr_q, buf_cnt_q;
	logic buf_wr;
	logic [31:0] buf_pc [3];
	logic [31:0] buf_inst [3];
	fetch_pkg::imem_err_e buf_err [3];
	logic buf_taken [3];
	logic buf_ill [3];
	logic [ID_W-1:0] buf_id [3];
	logic [ID_W-1:0] id_cnt_q;

	// wrap at 3 entries
	function automatic logic [1:0] inc3(input logic [1:0] p);
		return (p == 2'd2) ? 2'd0 : p + 2'd1;
	endfunction

	assign req_fire = imem.req_valid & imem.req_ready;
	assign take = if_res_valid_o & if_res_ready_i;
	assign supp = imem.rsp_valid & (flush_i | stale_q[iss_rptr_q]);	// old-path response
	assign vld_rsp = imem.rsp_valid & ~supp;
	assign inst_vld = vld_rsp | hold_vld_q;

	assign flushing_o = flush_i | flush_pend_q;
	assign flush_addr_hold_o = flush_i ? flush_addr_i : flush_addr_q;
	assign flush_ack_o = flushing_o & req_fire;
	assign first_fetch_o = first_q;

	assign cur_pc_o = hold_vld_q ? hold_pc_q : pc_buf[iss_rptr_q];
	assign cur_inst_o = hold_vld_q ? hold_inst_q : imem.rsp_rdata;

	// at most 3 requests between issue and hand-off
	assign imem.req_valid = (out_cnt_q < 3'd3) & (flushing_o | first_q | inst_vld);
	assign imem.req_addr = next_pc_i;

	assign buf_wr = vld_rsp;
	assign if_res_valid_o = ~flush_i & (buf_cnt_q != 2'd0);	// flush empties the buffer
	assign if_res_pc_o = buf_pc[buf_rptr_q];
	assign if_res_inst_o = buf_inst[buf_rptr_q];
	assign if_res_err_o = buf_err[buf_rptr_q];
	assign if_res_pred_taken_o = buf_taken[buf_rptr_q];
	assign if_res_illegal_o = buf_ill[buf_rptr_q];
	assign if_res_id_o = buf_id[buf_rptr_q];

	// buffered results vanish on flush, count them out at once
	assign out_cnt_base = flush_i ? out_cnt_q - {1'b0, buf_cnt_q} : out_cnt_q;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			boot_q <= 1'b0;
			first_q <= 1'b0;
			flush_pend_q <= 1'b0;
			out_cnt_q <= 3'd0;
			iss_wptr_q <= 2'd0;
			iss_rptr_q <= 2'd0;
			stale_q <= 3'b000;
			hold_vld_q <= 1'b0;
			buf_wptr_q <= 2'd0;
			buf_rptr_q <= 2'd0;
			buf_cnt_q <= 2'd0;
			id_cnt_q <= '0;
		end
		else
		begin
			boot_q <= 1'b1;
			first_q <= first_q ? ~req_fire : ~boot_q;	// one shot after release
			flush_pend_q <= (flush_pend_q | flush_i) & ~req_fire;
			out_cnt_q <= out_cnt_base + {2'b0, req_fire} - {2'b0, take} - {2'b0, supp};
			if (req_fire)
				iss_wptr_q <= inc3(iss_wptr_q);
			if (imem.rsp_valid)
				iss_rptr_q <= inc3(iss_rptr_q);	// every response retires one entry
			if (flush_i)
				stale_q <= 3'b111;	// all requests so far are old path
			if (req_fire)
				stale_q[iss_wptr_q] <= 1'b0;	// new request is live
			if (flushing_o | req_fire)
				hold_vld_q <= 1'b0;
			else if (vld_rsp)
				hold_vld_q <= 1'b1;	// could not issue its successor yet
			if (flush_i)
			begin
				buf_wptr_q <= 2'd0;
				buf_rptr_q <= 2'd0;
				buf_cnt_q <= 2'd0;
			end
			else
			begin
				if (buf_wr)
					buf_wptr_q <= inc3(buf_wptr_q);
				if (take)
					buf_rptr_q <= inc3(buf_rptr_q);
				buf_cnt_q <= buf_cnt_q + {1'b0, buf_wr} - {1'b0, take};
			end
			if (buf_wr)
				id_cnt_q <= id_cnt_q + 1'b1;	// keeps counting across flushes
		end
	end

	// payload, no reset
	always_ff @(posedge clk)
	begin
		if (flush_i)
			flush_addr_q <= flush_addr_i;
		if (req_fire)
			pc_buf[iss_wptr_q] <= imem.req_addr;
		if (vld_rsp)
		begin
			hold_inst_q <= imem.rsp_rdata;
			hold_pc_q <= pc_buf[iss_rptr_q];
		end
		if (buf_wr)
		begin
			buf_pc[buf_wptr_q] <= pc_buf[iss_rptr_q];
			buf_inst[buf_wptr_q] <= imem.rsp_rdata;
			buf_err[buf_wptr_q] <= imem.rsp_err;
			buf_taken[buf_wptr_q] <= pred_taken_i;
			buf_ill[buf_wptr_q] <= illegal_i;
			buf_id[buf_wptr_q] <= id_cnt_q;
		end
	end

	// a response always has a free slot, the count reserves it at issue
	a_buf_no_overflow: assert property (@(posedge clk) disable iff (!resetn)
		buf_wr |-> (buf_cnt_q != 2'd3));

	a_out_cnt_max: assert property (@(posedge clk) disable iff (!resetn)
		out_cnt_q <= 3'd3);

endmodule

// File: src/wb_imem_master.sv
`timescale 1ns/1ps

module wb_imem_master #(
	parameter int TIMEOUT_CYCLES = 16
)(
	input logic clk,
	input logic resetn,
	imem_req_if.master imem,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic [wb_pkg::ADDR_W-1:0] wb_adr_o,
	input logic [31:0] wb_dat_i,
	input logic wb_ack_i,
	input logic wb_err_i
);

	localparam int TMO_W = $clog2(TIMEOUT_CYCLES + 1);

	wb_pkg::wb_state_e state_q;
	logic misal_q;	// no bus cycle, answer with unaligned
	logic [TMO_W-1:0] tmo_cnt_q;
	logic tmo_hit, cyc_end;
	logic [wb_pkg::ADDR_W-1:0] adr_q;
	logic [31:0] rdata_q;
	fetch_pkg::imem_err_e err_q;

	assign tmo_hit = (tmo_cnt_q == TMO_W'(TIMEOUT_CYCLES - 1));
	assign cyc_end = misal_q | wb_ack_i | wb_err_i | tmo_hit;

	assign imem.req_ready = (state_q == wb_pkg::WB_IDLE);
	assign imem.rsp_valid = (state_q == wb_pkg::WB_RESP);	// one cycle after ack/err
	assign imem.rsp_rdata = rdata_q;
	assign imem.rsp_err = err_q;

	assign wb_cyc_o = (state_q == wb_pkg::WB_CYCLE) & ~misal_q;
	assign wb_stb_o = wb_cyc_o;	// classic, single transfer
	assign wb_adr_o = adr_q;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			state_q <= wb_pkg::WB_IDLE;
			misal_q <= 1'b0;
			tmo_cnt_q <= '0;
		end
		else
		begin
			case (state_q)
				wb_pkg::WB_IDLE:
				begin
					if (imem.req_valid)
					begin
						state_q <= wb_pkg::WB_CYCLE;
						misal_q <= |imem.req_addr[1:0];
						tmo_cnt_q <= '0;
					end
				end
				wb_pkg::WB_CYCLE:
				begin
					if (cyc_end)
						state_q <= wb_pkg::WB_RESP;
					else
						tmo_cnt_q <= tmo_cnt_q + 1'b1;
				end
				default: state_q <= wb_pkg::WB_IDLE;	// resp lasts one cycle
			endcase
		end
	end

	// address and response payload
	always_ff @(posedge clk)
	begin
		if (imem.req_ready & imem.req_valid)
			adr_q <= imem.req_addr;
		if ((state_q == wb_pkg::WB_CYCLE) & cyc_end)
		begin
			// error data zeroed so it decodes as illegal
			rdata_q <= (wb_ack_i & ~wb_err_i & ~misal_q) ? wb_dat_i : 32'd0;
			if (misal_q)
				err_q <= fetch_pkg::IMEM_UNALIGNED;
			else if (wb_err_i)
				err_q <= fetch_pkg::IMEM_BUS_ERR;
			else if (wb_ack_i)
				err_q <= fetch_pkg::IMEM_OK;
			else
				err_q <= fetch_pkg::IMEM_TIMEOUT;
		end
	end

	// stb and cyc both released in the cycle after ack or err
	a_stb_release: assert property (@(posedge clk) disable iff (!resetn)
		(wb_stb_o & (wb_ack_i | wb_err_i)) |=> !(wb_stb_o | wb_cyc_o));

	// address frozen for the whole strobe
	a_adr_stable: assert property (@(posedge clk) disable iff (!resetn)
		(wb_stb_o & $past(wb_stb_o)) |-> $stable(wb_adr_o));

endmodule

// File: src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = 32'h0000_0000,
	parameter int ID_W = 4,
	parameter int TIMEOUT_CYCLES = 16
)(
	input logic clk,
	input logic resetn,
	output logic wb_cyc_o,
	output logic wb_stb_o,
	output logic [wb_pkg::ADDR_W-1:0] wb_adr_o,
	input logic [fetch_pkg::XLEN-1:0] wb_dat_i,
	input logic wb_ack_i,
	input logic wb_err_i,
	output logic if_res_valid_o,
	input logic if_res_ready_i,
	output logic [fetch_pkg::XLEN-1:0] if_res_pc_o,
	output logic [fetch_pkg::XLEN-1:0] if_res_inst_o,
	output logic [fetch_pkg::ERR_W-1:0] if_res_err_o,
	output logic if_res_pred_taken_o,
	output logic if_res_illegal_o,
	output logic [ID_W-1:0] if_res_id_o,
	input logic flush_i,
	input logic [fetch_pkg::XLEN-1:0] flush_addr_i,
	output logic flush_ack_o
);

	logic [fetch_pkg::XLEN-1:0] cur_pc, cur_inst, next_pc, flush_addr_hold, pred_target;
	logic first_fetch, flushing, pred_taken, illegal;

	imem_req_if i_imem_if ();

	fetch_ctrl #(.ID_W(ID_W)) i_fetch_ctrl (
		.clk(clk), .resetn(resetn), .flush_i(flush_i), .flush_addr_i(flush_addr_i),
		.imem(i_imem_if.ctrl), .cur_pc_o(cur_pc), .cur_inst_o(cur_inst),
		.first_fetch_o(first_fetch), .flushing_o(flushing),
		.flush_addr_hold_o(flush_addr_hold), .next_pc_i(next_pc),
		.illegal_i(illegal), .pred_taken_i(pred_taken),
		.if_res_valid_o(if_res_valid_o), .if_res_ready_i(if_res_ready_i),
		.if_res_pc_o(if_res_pc_o), .if_res_inst_o(if_res_inst_o),
		.if_res_err_o(if_res_err_o), .if_res_pred_taken_o(if_res_pred_taken_o),
		.if_res_illegal_o(if_res_illegal_o), .if_res_id_o(if_res_id_o),
		.flush_ack_o(flush_ack_o));

	pc_gen #(.RESET_PC(RESET_PC)) i_pc_gen (
		.first_fetch_i(first_fetch), .flushing_i(flushing), .flush_addr_i(flush_addr_hold),
		.cur_pc_i(cur_pc), .pred_taken_i(pred_taken), .pred_target_i(pred_target),
		.next_pc_o(next_pc));

	pre_decoder i_pre_decoder (
		.inst_i(cur_inst), .pc_i(cur_pc), .pred_taken_o(pred_taken),
		.pred_target_o(pred_target), .illegal_o(illegal));

	wb_imem_master #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_wb_imem_master (
		.clk(clk), .resetn(resetn), .imem(i_imem_if.master),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
		.wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i), .wb_err_i(wb_err_i));

endmodule

// File: tests/wb_mem_model.sv
`timescale 1ns/1ps

module wb_mem_model (
	input logic clk,
	input logic resetn,
	input logic wb_cyc_i,
	input logic wb_stb_i,
	input logic [31:0] wb_adr_i,
	output logic [31:0] wb_dat_o,
	output logic wb_ack_o,
	output logic wb_err_o
);

	logic start, err_zone, silent_zone;

	// word follows from the word address alone
	function automatic logic [31:0] mem_word(input logic [31:0] adr);
		int unsigned w;
		w = adr >> 2;
		if (w % 11 == 0)
			return {w[29:0], 2'b00};	// low bits 00, illegal
		if (w % 13 == 0)
			return {1'b1, 6'b111111, 5'd2, 5'd1, 3'b001, 4'b0100, 1'b1, 7'b1100011};	// bne -24
		if (w % 8 == 0)
			return {1'b0, 10'd8, 1'b0, 8'd0, 5'd1, 7'b1101111};	// jal +16
		return {w[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011};	// addi x1, x1, imm
	endfunction

	assign err_zone = (wb_adr_i >= 32'h1000) && (wb_adr_i <= 32'h10ff);
	assign silent_zone = (wb_adr_i >= 32'h2000);	// never answers
	assign start = wb_cyc_i & wb_stb_i & ~wb_ack_o & ~wb_err_o;
	assign wb_dat_o = mem_word(wb_adr_i);

	// one wait state, then a single-cycle ack or err
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			wb_ack_o <= 1'b0;
			wb_err_o <= 1'b0;
		end
		else
		begin
			wb_ack_o <= start & ~err_zone & ~silent_zone;
			wb_err_o <= start & err_zone;
		end
	end

endmodule

// File: tests/tb_fetch_unit.sv
`timescale 1ns/1ps

module tb_fetch_unit;

	localparam logic [31:0] RESET_PC = 32'h0000_0100;
	localparam int ID_W = 4;
	localparam int TIMEOUT_CYCLES = 16;

	// kinds of pattern words
	localparam int K_ADDI = 0;
	localparam int K_JAL = 1;
	localparam int K_BRANCH = 2;
	localparam int K_ILLEGAL = 3;

	logic clk, resetn;
	logic wb_cyc_o, wb_stb_o, wb_ack_i, wb_err_i;
	logic [31:0] wb_adr_o, wb_dat_i;
	logic if_res_valid_o, if_res_ready_i, if_res_pred_taken_o, if_res_illegal_o;
	logic [31:0] if_res_pc_o, if_res_inst_o;
	logic [1:0] if_res_err_o;
	logic [ID_W-1:0] if_res_id_o;
	logic flush_i, flush_ack_o;
	logic [31:0] flush_addr_i;

	logic [31:0] lfsr;	// back-pressure source
	int ready_mode;	// 0 stall, 1 always ready, 2 random
	int drop_cnt;	// results the next flush throws away
	int failures;
	logic [31:0] exp_pc = RESET_PC;	// reference pc, follows the prediction rule
	logic [ID_W-1:0] exp_id = '0;
	int takes = 0;
	int acks = 0;
	int checks = 0;
	int mismatches = 0;

	fetch_unit #(.RESET_PC(RESET_PC), .ID_W(ID_W), .TIMEOUT_CYCLES(TIMEOUT_CYCLES)) i_fetch_unit (
		.clk(clk), .resetn(resetn),
		.wb_cyc_o(wb_cyc_o), .wb_stb_o(wb_stb_o), .wb_adr_o(wb_adr_o),
		.wb_dat_i(wb_dat_i), .wb_ack_i(wb_ack_i), .wb_err_i(wb_err_i),
		.if_res_valid_o(if_res_valid_o), .if_res_ready_i(if_res_ready_i),
		.if_res_pc_o(if_res_pc_o), .if_res_inst_o(if_res_inst_o),
		.if_res_err_o(if_res_err_o), .if_res_pred_taken_o(if_res_pred_taken_o),
		.if_res_illegal_o(if_res_illegal_o), .if_res_id_o(if_res_id_o),
		.flush_i(flush_i), .flush_addr_i(flush_addr_i), .flush_ack_o(flush_ack_o));

	wb_mem_model i_wb_mem_model (
		.clk(clk), .resetn(resetn), .wb_cyc_i(wb_cyc_o), .wb_stb_i(wb_stb_o),
		.wb_adr_i(wb_adr_o), .wb_dat_o(wb_dat_i), .wb_ack_o(wb_ack_i), .wb_err_o(wb_err_i));

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	function automatic int word_kind(input logic [31:0] pc);
		int unsigned w;
		w = pc >> 2;
		if (w % 11 == 0)
			return K_ILLEGAL;
		if (w % 13 == 0)
			return K_BRANCH;	// always backward
		if (w % 8 == 0)
			return K_JAL;
		return K_ADDI;
	endfunction

	function automatic logic [31:0] pattern_word(input logic [31:0] pc);
		int unsigned w;
		w = pc >> 2;
		case (word_kind(pc))
			K_ILLEGAL: return {w[29:0], 2'b00};
			K_BRANCH: return {1'b1, 6'b111111, 5'd2, 5'd1, 3'b001, 4'b0100, 1'b1, 7'b1100011};
			K_JAL: return {1'b0, 10'd8, 1'b0, 8'd0, 5'd1, 7'b1101111};
			default: return {w[11:0], 5'd1, 3'b000, 5'd1, 7'b0010011};
		endcase
	endfunction

	// status by address region
	function automatic logic [1:0] region_status(input logic [31:0] pc);
		if (pc[1:0] != 2'b00)
			return fetch_pkg::IMEM_UNALIGNED;
		if ((pc >= 32'h1000) && (pc <= 32'h10ff))
			return fetch_pkg::IMEM_BUS_ERR;
		if (pc >= 32'h2000)
			return fetch_pkg::IMEM_TIMEOUT;
		return fetch_pkg::IMEM_OK;
	endfunction

	function automatic logic [31:0] next_fetch_pc(input logic [31:0] pc, input logic [1:0] err);
		if (err != fetch_pkg::IMEM_OK)
			return pc + 32'd4;	// no word, falls through
		case (word_kind(pc))
			K_JAL: return pc + 32'd16;
			K_BRANCH: return pc - 32'd24;
			default: return pc + 32'd4;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		mismatches++;
		$display("Error: %s = 0x%h, expected 0x%h", name, got, exp);
	endtask

	// one cycle, inputs change on the falling edge
	task automatic tick();
		@(negedge clk);
		case (ready_mode)
			0: if_res_ready_i = 1'b0;
			1: if_res_ready_i = 1'b1;
			default:
			begin
				if_res_ready_i = lfsr[0];
				lfsr = lfsr_next(lfsr);
			end
		endcase
	endtask

	task automatic wait_results(input int n);
		int target;
		int cnt;
		target = takes + n;
		cnt = 0;
		while ((takes < target) && (cnt < n * 100))
		begin
			tick();
			cnt++;
		end
		assert (takes >= target) else
		begin
			failures++;
			$display("timeout, %0d of %0d results still missing", target - takes, n);
		end
	endtask

	// redirect, either from a drained or from a full result buffer
	task automatic redirect(input logic [31:0] addr, input logic full);
		int cnt;
		int acks_before;
		int quiet;
		cnt = 0;
		quiet = 0;
		if (full)
		begin
			ready_mode = 0;
			// full buffer stops issue, so the bus goes quiet
			while (!(if_res_valid_o && (quiet >= 8)) && (cnt < 100))
			begin
				tick();
				quiet = wb_cyc_o ? 0 : quiet + 1;
				cnt++;
			end
			drop_cnt = 3;
			assert (if_res_valid_o && (quiet >= 8)) else
			begin
				failures++;
				$display("timeout, result buffer did not fill under back-pressure");
			end
		end
		else
		begin
			ready_mode = 1;
			tick();
			while (if_res_valid_o && (cnt < 50))
			begin
				tick();
				cnt++;
			end
			drop_cnt = 0;
			assert (!if_res_valid_o) else
			begin
				failures++;
				$display("timeout, result buffer did not drain");
			end
		end
		acks_before = acks;
		flush_i = 1'b1;
		flush_addr_i = addr;
		tick();
		flush_i = 1'b0;
		cnt = 0;
		while ((acks == acks_before) && (cnt < 100))	// covers a full bus timeout
		begin
			tick();
			cnt++;
		end
		assert (acks != acks_before) else
		begin
			failures++;
			$display("no flush acknowledge after redirect to 0x%h", addr);
		end
		ready_mode = 2;
	endtask

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;	// 40 ns period
	end

	// reference model, sampled just before each rising edge
	always @(posedge clk)
	begin
		int kind;
		logic [1:0] err;
		if (resetn)
		begin
			// classic bus, word fetches only
			assert (wb_stb_o == wb_cyc_o) else
			begin
				failures++;
				$display("wb_cyc_o and wb_stb_o not raised and dropped together");
			end
			assert (!wb_cyc_o || (wb_adr_o[1:0] == 2'b00)) else
			begin
				failures++;
				$display("bus cycle started on misaligned address 0x%h", wb_adr_o);
			end
			if (flush_ack_o)
				acks++;
			if (flush_i)
			begin
				exp_pc = flush_addr_i;	// old path gone
				exp_id = exp_id + ID_W'(drop_cnt);	// ids of dropped results stay used
				assert (!if_res_valid_o) else
					report_mismatch("if_res_valid_o", 32'(if_res_valid_o), 32'd0);
			end
			else if (if_res_valid_o && if_res_ready_i)
			begin
				err = region_status(exp_pc);
				kind = word_kind(exp_pc);
				checks++;
				assert (if_res_pc_o == exp_pc) else
					report_mismatch("if_res_pc_o", if_res_pc_o, exp_pc);
				assert (if_res_id_o == exp_id) else
					report_mismatch("if_res_id_o", 32'(if_res_id_o), 32'(exp_id));
				assert (if_res_err_o == err) else
					report_mismatch("if_res_err_o", 32'(if_res_err_o), 32'(err));
				if (err == fetch_pkg::IMEM_OK)
				begin
					assert (if_res_inst_o == pattern_word(exp_pc)) else
						report_mismatch("if_res_inst_o", if_res_inst_o,
							pattern_word(exp_pc));
					assert (if_res_illegal_o == (kind == K_ILLEGAL)) else
						report_mismatch("if_res_illegal_o", 32'(if_res_illegal_o),
							32'(kind == K_ILLEGAL));
					assert (if_res_pred_taken_o == ((kind == K_JAL) || (kind == K_BRANCH))) else
						report_mismatch("if_res_pred_taken_o", 32'(if_res_pred_taken_o),
							32'((kind == K_JAL) || (kind == K_BRANCH)));
				end
				exp_pc = next_fetch_pc(exp_pc, err);
				exp_id = exp_id + 1'b1;	// wraps at 2^ID_W
				takes++;
			end
		end
	end

	initial
	begin
		resetn = 1'b0;
		flush_i = 1'b0;
		flush_addr_i = '0;
		if_res_ready_i = 1'b0;
		lfsr = 32'hcb01;
		ready_mode = 2;
		drop_cnt = 0;
		failures = 0;
		repeat (16) @(negedge clk);
		assert (!(if_res_valid_o | flush_ack_o | wb_cyc_o | wb_stb_o)) else
		begin
			failures++;
			$display("outputs not idle while in reset");
		end
		resetn = 1'b1;
		wait_results(40);	// boot path under random back-pressure
		redirect(32'h0000_0400, 1'b0);
		wait_results(20);
		redirect(32'h0000_0600, 1'b1);
		wait_results(20);
		redirect(32'h0000_0302, 1'b0);	// misaligned
		wait_results(3);
		redirect(32'h0000_1000, 1'b0);	// err region
		wait_results(3);
		redirect(32'h0000_2000, 1'b0);	// no ack at all
		wait_results(2);
		redirect(RESET_PC, 1'b0);
		wait_results(20);
		$display("results checked: %0d, mismatches: %0d, other failures: %0d",
			checks, mismatches, failures);
		if ((mismatches == 0) && (failures == 0))
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// File: vlog.f
src/fetch_pkg.sv
src/wb_pkg.sv
src/imem_req_if.sv
src/pc_gen.sv
src/pre_decoder.sv
src/fetch_ctrl.sv
src/wb_imem_master.sv
src/fetch_unit.sv
tests/wb_mem_model.sv
tests/tb_fetch_unit.sv

// File: run.sh
#!/bin/sh
# build and run the fetch unit testbench with verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --Mdir obj_dir --top-module tb_fetch_unit -f vlog.f
./obj_dir/Vtb_fetch_unit > sim.log 2>&1
cat sim.log
if grep -q "Finished with errors" sim.log
then
	exit 1
fi
